/* logic/console_reset_gen.sv */
// Console reset generator
// Holds the NES in reset until the first download, during and after
// a download and on loader error, and latches the mapper flags

`timescale 1ns/1ps

module console_reset_gen (
	input  logic                          clk,
	input  logic                          sys_reset,
	input  logic                          download,
	input  logic                          busy,
	input  logic                          done,
	input  logic                          error,
	input  nes_loader_pkg::mapper_flags_t decoded_flags,
	output logic                          reset_nes,
	output nes_loader_pkg::mapper_flags_t mapper_flags
);
	import nes_loader_pkg::*;

	logic                     init_done; // First download seen
	logic [HOLD_CNT_BITS-1:0] hold_cnt;  // Post-download settling

	always_ff @(posedge clk) begin
		if (sys_reset) begin
			init_done    <= 1'b0;
			hold_cnt     <= '0;
			mapper_flags <= '0;
		end else begin
			if (download)
				init_done <= 1'b1;

			// Count only once the loader has let go
			if (download)
				hold_cnt <= HOLD_CNT_BITS'(RESET_HOLD_CYCLES);
			else if (!busy && hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			if (done)
				mapper_flags <= decoded_flags;
		end
	end

	assign reset_nes = !init_done || download || (hold_cnt != '0) || error;

	// A load can only finish once a download has started
	a_done_after_download: assert property (@(posedge clk) disable iff (sys_reset)
		done |-> init_done);

endmodule

/* logic/ines_header_decode.sv */
// iNES / NES 2.0 header decoder
// Checks the magic and trainer bit, derives payload sizes and
// builds the mapper flag word, all combinational

`timescale 1ns/1ps

module ines_header_decode (
	input  nes_loader_pkg::byte_t [nes_loader_pkg::INES_HDR_BYTES-1:0] header_bytes,
	input  logic                          invert_mirroring,
	output logic                          header_valid,
	output nes_loader_pkg::byte_count_t   prg_bytes,
	output nes_loader_pkg::byte_count_t   chr_bytes,
	output nes_loader_pkg::mapper_flags_t decoded_flags
);
	import nes_loader_pkg::*;

	byte_t prg_pages; // Header byte 4
	byte_t chr_pages; // Header byte 5
	byte_t flags6;
	byte_t flags7;
	logic  magic_ok;
	logic  has_trainer;
	logic  is_nes20;
	logic  is_dirty;

	// Smallest power of two that holds the page count, capped at 7
	function automatic size_code_t size_class(input byte_t pages);
		size_code_t code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (8'd1 << i))
				code = size_code_t'(i);
		end
		return code;
	endfunction

	assign prg_pages = header_bytes[4];
	assign chr_pages = header_bytes[5];
	assign flags6    = header_bytes[6];
	assign flags7    = header_bytes[7];

	//////////////////////////////////////////////////
	// Header checks
	//////////////////////////////////////////////////

	assign magic_ok = (header_bytes[0] == INES_MAGIC_0) &&
	                  (header_bytes[1] == INES_MAGIC_1) &&
	                  (header_bytes[2] == INES_MAGIC_2) &&
	                  (header_bytes[3] == INES_MAGIC_3);

	assign has_trainer  = flags6[2];            // Trainers not supported
	assign header_valid = magic_ok && !has_trainer;

	assign is_nes20 = (flags7[3:2] == 2'b10);

	// Old dumps often carry junk in the tail of the header
	assign is_dirty = !is_nes20 &&
	                  ((header_bytes[9][7:1] != 7'd0) || (|header_bytes[15:10]));

	//////////////////////////////////////////////////
	// Payload sizes
	//////////////////////////////////////////////////

	assign prg_bytes = byte_count_t'(prg_pages) << PRG_PAGE_SHIFT;
	assign chr_bytes = byte_count_t'(chr_pages) << CHR_PAGE_SHIFT;

	//////////////////////////////////////////////////
	// Mapper flag word
	//////////////////////////////////////////////////

	always_comb begin
		decoded_flags = '0;
		decoded_flags.spare       = 1'b0;
		decoded_flags.piano       = is_nes20 && (header_bytes[15][5:0] == 6'h19);
		decoded_flags.has_saves   = flags6[1];
		decoded_flags.four_screen = flags6[3];
		decoded_flags.chr_ram     = (chr_pages == 8'd0);
		decoded_flags.mirroring   = flags6[0] ^ invert_mirroring;
		decoded_flags.chr_size    = size_class(chr_pages);
		decoded_flags.prg_size    = size_class(prg_pages);

		// Low nibble from byte 6, high nibble only from a clean header
		decoded_flags.mapper = {is_dirty ? 4'h0 : flags7[7:4], flags6[7:4]};

		if (is_nes20) begin
			decoded_flags.submapper     = header_bytes[8];
			decoded_flags.prg_ram_shift = header_bytes[10][3:0];
		end
	end

endmodule

/* logic/nes_loader_pkg.sv */
// Cartridge loader shared definitions
// Widths, iNES header constants, loader states and bus structs

package nes_loader_pkg;

	//////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////

	typedef logic [7:0]  byte_t;       // File or memory byte
	typedef logic [21:0] rom_addr_t;   // Loader memory address
	typedef logic [21:0] byte_count_t; // Bytes left to stream
	typedef logic [2:0]  size_code_t;  // Power-of-two size class

	//////////////////////////////////////////////////
	// iNES header constants
	//////////////////////////////////////////////////

	localparam int INES_HDR_BYTES = 16;
	localparam int HDR_IDX_BITS = $clog2(INES_HDR_BYTES);

	localparam byte_t INES_MAGIC_0 = 8'h4E; // "N"
	localparam byte_t INES_MAGIC_1 = 8'h45; // "E"
	localparam byte_t INES_MAGIC_2 = 8'h53; // "S"
	localparam byte_t INES_MAGIC_3 = 8'h1A; // DOS end of file

	localparam int PRG_PAGE_SHIFT = 14; // 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13; // 8 KiB pages

	// CHR ROM sits in the upper half of the loader space
	localparam rom_addr_t CHR_BASE_ADDR = 22'h200000;

	// Console reset hold after a download
	localparam int RESET_HOLD_CYCLES = 255;
	localparam int HOLD_CNT_BITS = $clog2(RESET_HOLD_CYCLES + 1);

	//////////////////////////////////////////////////
	// Structs and states
	//////////////////////////////////////////////////

	// Mapper flag word as seen by the console core
	typedef struct packed {
		logic       spare;
		logic       piano;         // Miracle piano attached
		logic [3:0] prg_ram_shift; // NES 2.0 PRG RAM size, 64 << n
		logic       has_saves;     // Battery backed RAM
		logic [7:0] submapper;
		logic       four_screen;
		logic       chr_ram;       // No CHR ROM on the cart
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic      write;
		rom_addr_t addr;
		byte_t     data;
	} mem_write_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} load_state_t;

endpackage

/* logic/nes_loader_top.sv */
// Cartridge loading front end
// Header decode, ROM load state machine and console reset generation

`timescale 1ns/1ps

module nes_loader_top (
	input  logic                          clk,
	input  logic                          sys_reset,
	input  logic                          download,
	input  nes_loader_pkg::byte_t         file_data,
	input  logic                          file_strobe,
	input  logic                          invert_mirroring,
	output nes_loader_pkg::mem_write_t    mem_wr,
	output logic                          busy,
	output logic                          done,
	output logic                          error,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          reset_nes
);
	import nes_loader_pkg::*;

	byte_t [INES_HDR_BYTES-1:0] header_bytes;
	logic                       header_valid;
	byte_count_t                prg_bytes;
	byte_count_t                chr_bytes;
	mapper_flags_t              decoded_flags;

	rom_load_fsm rom_load_fsm_i (
		.clk          (clk),
		.sys_reset    (sys_reset),
		.download     (download),
		.file_data    (file_data),
		.file_strobe  (file_strobe),
		.header_valid (header_valid),
		.prg_bytes    (prg_bytes),
		.chr_bytes    (chr_bytes),
		.header_bytes (header_bytes),
		.mem_wr       (mem_wr),
		.busy         (busy),
		.done         (done),
		.error        (error)
	);

	ines_header_decode ines_header_decode_i (
		.header_bytes     (header_bytes),
		.invert_mirroring (invert_mirroring),
		.header_valid     (header_valid),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.decoded_flags    (decoded_flags)
	);

	console_reset_gen console_reset_gen_i (
		.clk           (clk),
		.sys_reset     (sys_reset),
		.download      (download),
		.busy          (busy),
		.done          (done),
		.error         (error),
		.decoded_flags (decoded_flags),
		.reset_nes     (reset_nes),
		.mapper_flags  (mapper_flags)
	);

endmodule

/* logic/rom_load_fsm.sv */
// ROM load state machine
// Captures the 16 header bytes, then streams PRG bytes from address 0
// and CHR bytes from the CHR base, and reports busy, done and error

`timescale 1ns/1ps

module rom_load_fsm (
	input  logic                        clk,
	input  logic                        sys_reset,
	input  logic                        download,
	input  nes_loader_pkg::byte_t       file_data,
	input  logic                        file_strobe,
	input  logic                        header_valid,
	input  nes_loader_pkg::byte_count_t prg_bytes,
	input  nes_loader_pkg::byte_count_t chr_bytes,
	output nes_loader_pkg::byte_t [nes_loader_pkg::INES_HDR_BYTES-1:0] header_bytes,
	output nes_loader_pkg::mem_write_t  mem_wr,
	output logic                        busy,
	output logic                        done,
	output logic                        error
);
	import nes_loader_pkg::*;

	load_state_t             state;
	logic [HDR_IDX_BITS-1:0] hdr_idx;    // Next header byte slot
	rom_addr_t               addr;
	byte_count_t             bytes_left;
	logic                    download_q;
	logic                    download_start;
	logic                    hdr_strobe;
	logic                    payload_state;

	assign download_start = download && !download_q;
	assign hdr_strobe     = (state == LOAD_HEADER) && download && file_strobe;
	assign payload_state  = (state == LOAD_PRG) || (state == LOAD_CHR);

	// Write goes out in the strobe cycle without buffering
	always_comb begin
		mem_wr.write = payload_state && (bytes_left != '0) && file_strobe;
		mem_wr.addr  = addr;
		mem_wr.data  = file_data;
	end

	always_ff @(posedge clk) begin
		if (sys_reset)
			download_q <= 1'b0;
		else
			download_q <= download;
	end

	// Header bytes are kept here and never go to memory
	always_ff @(posedge clk) begin
		if (hdr_strobe)
			header_bytes[hdr_idx] <= file_data;
	end

	//////////////////////////////////////////////////
	// Load sequence
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (sys_reset || download_start) begin // A new file restarts the loader
			state      <= LOAD_HEADER;
			hdr_idx    <= '0;
			addr       <= '0;
			bytes_left <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				LOAD_HEADER: begin
					if (hdr_strobe) begin
						hdr_idx <= hdr_idx + 1'b1;
						// Magic, trainer bit and byte 4 are already stored here
						if (hdr_idx == HDR_IDX_BITS'(INES_HDR_BYTES - 1)) begin
							busy       <= 1'b1;
							addr       <= '0;
							bytes_left <= prg_bytes;
							state      <= header_valid ? LOAD_PRG : LOAD_ERROR;
						end
					end
				end

				LOAD_PRG, LOAD_CHR: begin
					if (bytes_left != '0) begin
						if (file_strobe) begin
							bytes_left <= bytes_left - 1'b1;
							addr       <= addr + 1'b1;
						end
					end else if (state == LOAD_PRG) begin
						// PRG finished and CHR may be empty
						state      <= LOAD_CHR;
						addr       <= CHR_BASE_ADDR;
						bytes_left <= chr_bytes;
					end else begin
						state <= LOAD_DONE;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end

				LOAD_ERROR: begin
					done  <= 1'b1;
					error <= 1'b1;
					busy  <= 1'b0;
				end

				LOAD_DONE: begin
					busy <= 1'b0; // Idle until the next download
				end

				default: state <= LOAD_HEADER;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Memory only written while a load is in progress
	a_write_in_payload: assert property (@(posedge clk) disable iff (sys_reset)
		mem_wr.write |-> busy);

	// Error always reported as a finished load
	a_error_done: assert property (@(posedge clk) disable iff (sys_reset)
		error |-> done);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the cartridge loader testbench with Verilator and run it.
# Exits nonzero unless the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
	--top-module tb_nes_loader \
	-Mdir obj_dir \
	-f src.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_nes_loader)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* src.f */
logic/nes_loader_pkg.sv
logic/ines_header_decode.sv
logic/rom_load_fsm.sv
logic/console_reset_gen.sv
logic/nes_loader_top.sv
test/tb_nes_loader.sv

/* test/loader_golden.hex */
// One case per line: header bytes 0-3, 4-7, 8-11, 12-15 (first byte in the top byte),
// invert_mirroring, expected mapper_flags, expected error
// iNES 1.0, 1 PRG, 1 CHR, vertical mirroring
4E45531A 01010100 00000000 00000000 0 00004000 0
// Same header with mirroring inverted
4E45531A 01010100 00000000 00000000 1 00000000 0
// 2 PRG, no CHR ROM, mapper 2
4E45531A 02002000 00000000 00000000 0 00008102 0
// Bad magic byte 3
4E455300 01000000 00000000 00000000 0 00008000 1
// Trainer present with battery RAM
4E45531A 01010600 00000000 00000000 0 02000000 1
// Dirty iNES 1.0 tail, high mapper nibble dropped
4E45531A 01011140 00000044 75646521 0 00004001 0
// Clean iNES 1.0, mapper 66, 2 PRG, 2 CHR
4E45531A 02022140 00000000 00000000 0 00004942 0
// NES 2.0, mapper 1, submapper 0x50, PRG RAM shift 7, piano
4E45531A 03011308 50000700 00000019 0 5EA04201 0
// NES 2.0, mapper 16, submapper 3, four screen, no piano
4E45531A 01020818 03007500 00000018 0 14070810 0

/* test/tb_nes_loader.sv */
// Testbench for the cartridge loading front end
// Replays golden headers with LFSR payload bytes and checks memory writes,
// mapper flags, busy, done, error and the console reset

`timescale 1ns/1ps

module tb_nes_loader;
	import nes_loader_pkg::*;

	localparam int          NUM_CASES      = 9;
	localparam int          CASE_WORDS     = 7; // 4 header words, invert, flags, error
	localparam int          PRG_PAGE_BYTES = 16384;
	localparam int          CHR_PAGE_BYTES = 8192;
	localparam logic [21:0] CHR_BASE       = 22'h200000;
	localparam logic [31:0] MIRROR_BIT     = 32'h0000_4000;
	localparam int          DONE_TIMEOUT   = 10;
	localparam int          HOLD_MIN       = 255;
	localparam int          HOLD_MAX       = 300;

	logic          clk;
	logic          sys_reset;
	logic          download;
	byte_t         file_data;
	logic          file_strobe;
	logic          invert_mirroring;
	mem_write_t    mem_wr;
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t mapper_flags;
	logic          reset_nes;

	logic [31:0] golden [0:NUM_CASES*CASE_WORDS-1];
	logic [31:0] lfsr_state;
	logic [21:0] wr_addr_q [$]; // Every write seen since time zero
	byte_t       wr_data_q [$];
	byte_t       sent_q [$];    // Payload bytes of the current case
	logic        seen_download;
	logic [31:0] prev_flags;
	logic        prev_invert;

	nes_loader_top nes_loader_top_i (
		.clk              (clk),
		.sys_reset        (sys_reset),
		.download         (download),
		.file_data        (file_data),
		.file_strobe      (file_strobe),
		.invert_mirroring (invert_mirroring),
		.mem_wr           (mem_wr),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags),
		.reset_nes        (reset_nes)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Failure reporting and helpers
	//////////////////////////////////////////////////

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		stop_on_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
			test, exp, act));
	endtask

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	function automatic byte_t random_byte();
		byte_t value;
		value = 8'h00;
		for (int i = 0; i < 8; i++) begin
			value      = {value[6:0], lfsr_state[0]}; // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	function automatic logic same_header_as_previous(input int idx);
		logic same;
		same = 1'b0;
		if (idx > 0) begin
			same = 1'b1;
			for (int w = 0; w < 4; w++) begin
				if (golden[idx*CASE_WORDS + w] != golden[(idx-1)*CASE_WORDS + w])
					same = 1'b0;
			end
		end
		return same;
	endfunction

	task automatic send_byte(input byte_t value);
		@(posedge clk);
		file_data   <= value;
		file_strobe <= 1'b1;
		@(posedge clk);
		file_strobe <= 1'b0; // Next strobe two cycles later
	endtask

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (mem_wr.write) begin
			wr_addr_q.push_back(mem_wr.addr);
			wr_data_q.push_back(mem_wr.data);
		end
	end

	// Console held before the first file and while a file streams in
	always @(negedge clk) begin
		if (!sys_reset && (!seen_download || download))
			assert (reset_nes) else stop_on_failure("reset_nes low before or during a download");
	end

	//////////////////////////////////////////////////
	// One golden case
	//////////////////////////////////////////////////

	task automatic run_case(input int idx);
		byte_t       hdr [16];
		logic [31:0] word;
		logic        inv;
		logic [31:0] exp_flags;
		logic        exp_error;
		logic [21:0] exp_addr;
		int          base;
		int          prg_count;
		int          chr_count;
		int          exp_writes;
		int          first_write;
		int          waited;
		int          held;
		string       name;

		base = idx * CASE_WORDS;
		name = $sformatf("case%0d", idx);
		for (int k = 0; k < 16; k++) begin
			word   = golden[base + k/4];
			hdr[k] = word[31 - 8*(k%4) -: 8]; // First byte in the top lane
		end
		inv         = golden[base + 4][0];
		exp_flags   = golden[base + 5];
		exp_error   = golden[base + 6][0];
		prg_count   = int'(hdr[4]) * PRG_PAGE_BYTES;
		chr_count   = int'(hdr[5]) * CHR_PAGE_BYTES;
		exp_writes  = exp_error ? 0 : prg_count + chr_count;
		first_write = wr_addr_q.size();
		sent_q.delete();

		@(posedge clk);
		download         <= 1'b1;
		invert_mirroring <= inv;
		seen_download    <= 1'b1;
		repeat (2) @(posedge clk);

		for (int k = 0; k < 16; k++)
			send_byte(hdr[k]);
		@(negedge clk);
		assert (busy) else report_mismatch({name, " busy after header"}, 32'd1, 32'(busy));

		// Payload goes out even for a bad header, nothing may reach memory then
		for (int n = 0; n < prg_count + chr_count; n++) begin
			sent_q.push_back(random_byte());
			send_byte(sent_q[n]);
		end

		@(negedge clk);
		waited = 0;
		while (!done && waited < DONE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		assert (done) else stop_on_failure({name, " timed out waiting for done"});
		assert (error == exp_error) else report_mismatch({name, " error"}, 32'(exp_error), 32'(error));
		assert (!busy) else report_mismatch({name, " busy after done"}, 32'd0, 32'(busy));

		assert (wr_addr_q.size() - first_write == exp_writes)
			else report_mismatch({name, " write count"}, 32'(exp_writes),
				32'(wr_addr_q.size() - first_write));
		for (int n = 0; n < exp_writes; n++) begin
			exp_addr = (n < prg_count) ? 22'(n) : CHR_BASE + 22'(n - prg_count);
			assert (wr_addr_q[first_write + n] == exp_addr)
				else report_mismatch({name, " write address"}, 32'(exp_addr),
					32'(wr_addr_q[first_write + n]));
			assert (wr_data_q[first_write + n] == sent_q[n])
				else report_mismatch({name, " write data"}, 32'(sent_q[n]),
					32'(wr_data_q[first_write + n]));
		end

		@(posedge clk);
		download <= 1'b0;
		@(negedge clk);
		held = 0;
		while (reset_nes && held <= HOLD_MAX) begin // Count cycles still in reset
			held++;
			@(negedge clk);
		end
		if (exp_error) begin
			assert (reset_nes) else stop_on_failure({name, " reset_nes released after a failed load"});
		end else begin
			assert (held >= HOLD_MIN && held <= HOLD_MAX)
				else report_mismatch({name, " reset hold cycles"}, 32'(HOLD_MIN), 32'(held));
		end

		assert (done) else stop_on_failure({name, " done dropped before the next download"});
		assert (mapper_flags == exp_flags)
			else report_mismatch({name, " mapper_flags"}, exp_flags, mapper_flags);
		if (same_header_as_previous(idx) && inv != prev_invert) begin
			assert ((mapper_flags ^ prev_flags) == MIRROR_BIT)
				else report_mismatch({name, " mirroring flip"}, MIRROR_BIT, mapper_flags ^ prev_flags);
		end
		prev_flags  = mapper_flags;
		prev_invert = inv;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		sys_reset        <= 1'b1;
		download         <= 1'b0;
		file_data        <= 8'h00;
		file_strobe      <= 1'b0;
		invert_mirroring <= 1'b0;
		seen_download    <= 1'b0;
		lfsr_state  = 32'ha13b_3bca;
		prev_flags  = 32'h0;
		prev_invert = 1'b0;
		for (int i = 0; i < NUM_CASES*CASE_WORDS; i++)
			golden[i] = 32'hFFFF_FFFF; // Shows a short golden file
		$readmemh("test/loader_golden.hex", golden);
		assert (golden[NUM_CASES*CASE_WORDS - 1] <= 32'd1)
			else stop_on_failure("golden file missing or too short");

		repeat (8) @(posedge clk);
		sys_reset <= 1'b0;
		repeat (20) @(posedge clk); // Idle with the console held

		for (int c = 0; c < NUM_CASES; c++)
			run_case(c);

		$display("TEST PASS");
		$finish;
	end

endmodule
